// File: cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int addr_w      = 32;
    localparam int word_w      = 32;
    localparam int block_words = 2;
    localparam int num_sets    = 16;
    localparam int byte_off_w  = 2;
    localparam int word_off_w  = $clog2(block_words);
    localparam int index_w     = $clog2(num_sets);
    localparam int index_lsb   = byte_off_w + word_off_w;
    localparam int tag_w       = addr_w - index_w - index_lsb;
    localparam int blk_addr_w  = tag_w + index_w;

    typedef logic [word_w-1:0] word_t;

    // Word 0 sits in the low half of a block
    typedef logic [block_words-1:0][word_w-1:0] block_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        word_t             wdata;
        logic              ren;
        logic              wen;
    } proc_req_t;

    typedef struct packed {
        word_t rdata;
        logic  busy;
    } proc_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        word_t             wdata;
        logic              ren;
        logic              wen;
    } mem_req_t;

endpackage

// File: coherence_pkg.sv
package coherence_pkg;

    typedef enum logic [1:0] {
        I,
        S,
        E,
        M
    } mesi_t;

    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_RD,
        BUS_RDX,
        BUS_UPGR,
        BUS_WB
    } bus_op_t;

    ////////////////////////////////////////////////////////////
    // Cache to controller
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        bus_op_t                               op;
        logic [cache_geom_pkg::blk_addr_w-1:0] blk_addr;
        cache_geom_pkg::block_t                wb_data;
    } bus_req_t;

    typedef struct packed {
        logic                   done;
        logic                   shared;
        cache_geom_pkg::block_t fill;
    } bus_rsp_t;

    ////////////////////////////////////////////////////////////
    // Snoop broadcast and reply
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                                  valid;
        bus_op_t                               op;
        logic [cache_geom_pkg::blk_addr_w-1:0] blk_addr;
    } snoop_t;

    typedef struct packed {
        logic                   hit;
        logic                   dirty;
        cache_geom_pkg::block_t data;
    } snoop_rsp_t;

    typedef struct packed {
        logic [31:0] invalidated_blocks;
        logic [31:0] shared_blocks;
        logic [31:0] to_s_transitions;
        logic [31:0] to_e_transitions;
    } coh_stats_t;

endpackage

// File: l1_cache.sv
module l1_cache (
    input  logic                      CLK,
    input  logic                      reset,
    input  cache_geom_pkg::proc_req_t proc_req,
    output cache_geom_pkg::proc_rsp_t proc_rsp,
    output coherence_pkg::bus_req_t   bus_req,
    input  coherence_pkg::bus_rsp_t   bus_rsp,
    input  coherence_pkg::snoop_t     snoop,
    output coherence_pkg::snoop_rsp_t snoop_rsp,
    input  logic                      flush,
    output logic                      flush_done,
    output coherence_pkg::coh_stats_t stats
);

    typedef enum logic [2:0] {
        IDLE,
        MISS,
        UPGRADE,
        FLUSH_WALK,
        FLUSH_WB
    } ctrl_state_t;

    ctrl_state_t ctrl;

    logic [cache_geom_pkg::tag_w-1:0] tags [cache_geom_pkg::num_sets];
    cache_geom_pkg::block_t           data [cache_geom_pkg::num_sets];
    coherence_pkg::mesi_t             state [cache_geom_pkg::num_sets];

    logic [cache_geom_pkg::index_w-1:0]    flush_idx;
    logic                                  flush_hold;
    logic [cache_geom_pkg::tag_w-1:0]      p_tag;
    logic [cache_geom_pkg::index_w-1:0]    p_idx;
    logic [cache_geom_pkg::word_off_w-1:0] p_word;
    logic [cache_geom_pkg::tag_w-1:0]      s_tag;
    logic [cache_geom_pkg::index_w-1:0]    s_idx;
    logic                                  p_req, p_hit, p_ok, p_conflict;
    logic                                  flush_start, walk_stall;
    logic                                  snoop_hit, snoop_to_s, snoop_to_i;
    logic                                  own_done, fill, fill_s, upgr_done;
    logic [1:0]                            shared_inc, shared_dec;
    coherence_pkg::bus_op_t                miss_op;

    always_comb begin
        p_tag  = proc_req.addr[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];
        p_idx  = proc_req.addr[cache_geom_pkg::index_lsb +: cache_geom_pkg::index_w];
        p_word = proc_req.addr[cache_geom_pkg::byte_off_w +: cache_geom_pkg::word_off_w];
        s_tag  = snoop.blk_addr[cache_geom_pkg::blk_addr_w-1 -: cache_geom_pkg::tag_w];
        s_idx  = snoop.blk_addr[cache_geom_pkg::index_w-1:0];

        // A snoop on the same set holds the processor off for one cycle
        p_req      = proc_req.ren || proc_req.wen;
        p_hit      = state[p_idx] != coherence_pkg::I && tags[p_idx] == p_tag;
        p_conflict = snoop.valid && s_idx == p_idx;
        p_ok       = p_hit && !p_conflict &&
                     (!proc_req.wen || state[p_idx] inside {coherence_pkg::E, coherence_pkg::M});

        proc_rsp.rdata = data[p_idx][p_word];
        proc_rsp.busy  = p_req && !(ctrl == IDLE && p_ok);

        snoop_hit       = snoop.valid && state[s_idx] != coherence_pkg::I && tags[s_idx] == s_tag;
        snoop_rsp.hit   = snoop_hit;
        snoop_rsp.dirty = snoop_hit && state[s_idx] == coherence_pkg::M;
        snoop_rsp.data  = data[s_idx];
        snoop_to_s      = snoop_hit && snoop.op == coherence_pkg::BUS_RD &&
                          state[s_idx] inside {coherence_pkg::E, coherence_pkg::M};
        snoop_to_i      = snoop_hit && (snoop.op == coherence_pkg::BUS_RDX ||
                                        snoop.op == coherence_pkg::BUS_UPGR);

        // Dirty victim goes out first, then the line is fetched or upgraded
        if (state[p_idx] == coherence_pkg::M && tags[p_idx] != p_tag)
            miss_op = coherence_pkg::BUS_WB;
        else if (p_hit && proc_req.wen && state[p_idx] == coherence_pkg::S)
            miss_op = coherence_pkg::BUS_UPGR;
        else
            miss_op = proc_req.wen ? coherence_pkg::BUS_RDX : coherence_pkg::BUS_RD;

        bus_req.op       = coherence_pkg::BUS_NONE;
        bus_req.blk_addr = {p_tag, p_idx};
        bus_req.wb_data  = data[p_idx];
        if (ctrl == MISS || ctrl == UPGRADE) begin
            bus_req.op = miss_op;
            if (miss_op == coherence_pkg::BUS_WB)
                bus_req.blk_addr = {tags[p_idx], p_idx};
        end else if (ctrl == FLUSH_WB) begin
            bus_req.op = state[flush_idx] == coherence_pkg::M ? coherence_pkg::BUS_WB
                                                              : coherence_pkg::BUS_NONE;
            bus_req.blk_addr = {tags[flush_idx], flush_idx};
            bus_req.wb_data  = data[flush_idx];
        end

        flush_start = ctrl == IDLE && flush && !flush_hold;
        walk_stall  = snoop.valid && s_idx == flush_idx;
        own_done    = (ctrl == MISS || ctrl == UPGRADE) && bus_rsp.done;
        fill        = own_done && (miss_op == coherence_pkg::BUS_RD ||
                                   miss_op == coherence_pkg::BUS_RDX);
        fill_s      = fill && miss_op == coherence_pkg::BUS_RD && bus_rsp.shared;
        upgr_done   = own_done && miss_op == coherence_pkg::BUS_UPGR;

        shared_inc = 2'(snoop_to_s) + 2'(fill_s);
        shared_dec = 2'(snoop_to_i && state[s_idx] == coherence_pkg::S)
                   + 2'(fill && state[p_idx] == coherence_pkg::S) + 2'(upgr_done)
                   + 2'(ctrl == FLUSH_WALK && !walk_stall && state[flush_idx] == coherence_pkg::S);
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            ctrl       <= IDLE;
            flush_idx  <= '0;
            flush_hold <= 1'b0;
            flush_done <= 1'b0;
            stats      <= '0;
            for (int i = 0; i < cache_geom_pkg::num_sets; i++)
                state[i] <= coherence_pkg::I;
        end else begin
            flush_done <= 1'b0;
            if (!flush)
                flush_hold <= 1'b0;

            stats.invalidated_blocks <= stats.invalidated_blocks + 32'(snoop_to_i);
            stats.shared_blocks <= stats.shared_blocks + 32'(shared_inc) - 32'(shared_dec);
            stats.to_s_transitions <= stats.to_s_transitions + 32'(snoop_to_s) + 32'(fill_s);
            stats.to_e_transitions <= stats.to_e_transitions + 32'(fill && !fill_s);

            if (snoop_to_s)
                state[s_idx] <= coherence_pkg::S;
            else if (snoop_to_i)
                state[s_idx] <= coherence_pkg::I;

            case (ctrl)
                IDLE: begin
                    if (flush_start) begin
                        ctrl      <= FLUSH_WALK;
                        flush_idx <= '0;
                    end else if (p_req && !p_ok && !p_conflict) begin
                        ctrl <= (p_hit && proc_req.wen) ? UPGRADE : MISS;
                    end
                    if (p_ok && proc_req.wen) begin
                        data[p_idx][p_word] <= proc_req.wdata;
                        state[p_idx]        <= coherence_pkg::M;
                    end
                end
                MISS, UPGRADE: begin
                    if (bus_rsp.done) begin
                        ctrl <= IDLE;
                        case (miss_op)
                            coherence_pkg::BUS_WB: begin
                                state[p_idx] <= coherence_pkg::I;
                                ctrl         <= MISS;
                            end
                            coherence_pkg::BUS_UPGR: state[p_idx] <= coherence_pkg::M;
                            default: begin
                                tags[p_idx]  <= p_tag;
                                data[p_idx]  <= bus_rsp.fill;
                                state[p_idx] <= fill_s ? coherence_pkg::S : coherence_pkg::E;
                            end
                        endcase
                    end else if (ctrl == UPGRADE && miss_op != coherence_pkg::BUS_UPGR) begin
                        // Lost the shared copy to another writer while waiting
                        ctrl <= MISS;
                    end
                end
                FLUSH_WALK: begin
                    if (!walk_stall) begin
                        if (state[flush_idx] == coherence_pkg::M) begin
                            ctrl <= FLUSH_WB;
                        end else begin
                            state[flush_idx] <= coherence_pkg::I;
                            flush_idx        <= flush_idx + 1'b1;
                            if (flush_idx == '1) begin
                                ctrl       <= IDLE;
                                flush_done <= 1'b1;
                                flush_hold <= 1'b1;
                            end
                        end
                    end
                end
                FLUSH_WB: begin
                    if (bus_rsp.done) begin
                        state[flush_idx] <= coherence_pkg::I;
                        ctrl             <= FLUSH_WALK;
                    end else if (state[flush_idx] != coherence_pkg::M) begin
                        ctrl <= FLUSH_WALK;
                    end
                end
                default: ctrl <= IDLE;
            endcase
        end
    end

endmodule

// File: bus_ctrl.sv
module bus_ctrl (
    input  logic                      CLK,
    input  logic                      reset,
    input  coherence_pkg::bus_req_t   bus_req0,
    input  coherence_pkg::bus_req_t   bus_req1,
    output coherence_pkg::bus_rsp_t   bus_rsp0,
    output coherence_pkg::bus_rsp_t   bus_rsp1,
    output coherence_pkg::snoop_t     snoop0,
    output coherence_pkg::snoop_t     snoop1,
    input  coherence_pkg::snoop_rsp_t snoop_rsp0,
    input  coherence_pkg::snoop_rsp_t snoop_rsp1,
    output cache_geom_pkg::mem_req_t  memory_req,
    input  cache_geom_pkg::word_t     memory_rdata,
    input  logic                      memory_busy
);

    typedef enum logic [2:0] {
        ARB,
        SNOOP,
        WB_WORD,
        RD_WORD,
        DONE
    } bus_state_t;

    bus_state_t                            state;
    logic                                  gnt, last_gnt, shared;
    logic                                  req0, req1, pick, need_read;
    logic [cache_geom_pkg::word_off_w-1:0] word_cnt;
    coherence_pkg::bus_req_t               cur;
    coherence_pkg::snoop_rsp_t             other_rsp;
    cache_geom_pkg::block_t                wb_blk, fill_blk;

    always_comb begin
        req0      = bus_req0.op != coherence_pkg::BUS_NONE;
        req1      = bus_req1.op != coherence_pkg::BUS_NONE;
        // Round robin: when both ask, the one not served last wins
        pick      = (req0 && req1) ? !last_gnt : req1;
        need_read = cur.op == coherence_pkg::BUS_RD || cur.op == coherence_pkg::BUS_RDX;
        other_rsp = gnt ? snoop_rsp0 : snoop_rsp1;

        snoop0 = '{valid: state == SNOOP && gnt, op: cur.op, blk_addr: cur.blk_addr};
        snoop1 = '{valid: state == SNOOP && !gnt, op: cur.op, blk_addr: cur.blk_addr};

        bus_rsp0 = '{done: state == DONE && !gnt, shared: shared, fill: fill_blk};
        bus_rsp1 = '{done: state == DONE && gnt, shared: shared, fill: fill_blk};

        memory_req.addr  = {cur.blk_addr, word_cnt, {cache_geom_pkg::byte_off_w{1'b0}}};
        memory_req.wdata = wb_blk[word_cnt];
        memory_req.ren   = state == RD_WORD;
        memory_req.wen   = state == WB_WORD;
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state    <= ARB;
            last_gnt <= 1'b0;
            word_cnt <= '0;
        end else begin
            case (state)
                ARB: begin
                    if (req0 || req1) begin
                        gnt      <= pick;
                        last_gnt <= pick;
                        cur      <= pick ? bus_req1 : bus_req0;
                        state    <= SNOOP;
                    end
                end
                SNOOP: begin
                    shared   <= other_rsp.hit;
                    word_cnt <= '0;
                    if (cur.op == coherence_pkg::BUS_WB) begin
                        wb_blk <= cur.wb_data;
                        state  <= WB_WORD;
                    end else if (other_rsp.dirty) begin
                        // Memory must be current before the requester reads it
                        wb_blk <= other_rsp.data;
                        state  <= WB_WORD;
                    end else begin
                        state <= need_read ? RD_WORD : DONE;
                    end
                end
                WB_WORD: begin
                    if (!memory_busy) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == '1)
                            state <= need_read ? RD_WORD : DONE;
                    end
                end
                RD_WORD: begin
                    if (!memory_busy) begin
                        fill_blk[word_cnt] <= memory_rdata;
                        word_cnt           <= word_cnt + 1'b1;
                        if (word_cnt == '1)
                            state <= DONE;
                    end
                end
                default: state <= ARB;
            endcase
        end
    end

endmodule

// File: cache_stress_wrapper.sv
module cache_stress_wrapper (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      cache0_flush,
    output logic                      cache0_flush_done,
    input  cache_geom_pkg::proc_req_t cache0_req,
    output cache_geom_pkg::proc_rsp_t cache0_rsp,
    input  logic                      cache1_flush,
    output logic                      cache1_flush_done,
    input  cache_geom_pkg::proc_req_t cache1_req,
    output cache_geom_pkg::proc_rsp_t cache1_rsp,
    output cache_geom_pkg::mem_req_t  memory_req,
    input  cache_geom_pkg::word_t     memory_rdata,
    input  logic                      memory_busy,
    output coherence_pkg::coh_stats_t cache0_stats,
    output coherence_pkg::coh_stats_t cache1_stats
);

    coherence_pkg::bus_req_t   bus_req0, bus_req1;
    coherence_pkg::bus_rsp_t   bus_rsp0, bus_rsp1;
    coherence_pkg::snoop_t     snoop0, snoop1;
    coherence_pkg::snoop_rsp_t snoop_rsp0, snoop_rsp1;

    ////////////////////////////////////////////////////////////
    // Two caches sharing one bus controller
    ////////////////////////////////////////////////////////////

    l1_cache cache0 (
        .CLK(CLK), .reset(reset),
        .proc_req(cache0_req), .proc_rsp(cache0_rsp),
        .bus_req(bus_req0), .bus_rsp(bus_rsp0),
        .snoop(snoop0), .snoop_rsp(snoop_rsp0),
        .flush(cache0_flush), .flush_done(cache0_flush_done),
        .stats(cache0_stats)
    );

    l1_cache cache1 (
        .CLK(CLK), .reset(reset),
        .proc_req(cache1_req), .proc_rsp(cache1_rsp),
        .bus_req(bus_req1), .bus_rsp(bus_rsp1),
        .snoop(snoop1), .snoop_rsp(snoop_rsp1),
        .flush(cache1_flush), .flush_done(cache1_flush_done),
        .stats(cache1_stats)
    );

    bus_ctrl bus (
        .CLK(CLK), .reset(reset),
        .bus_req0(bus_req0), .bus_req1(bus_req1),
        .bus_rsp0(bus_rsp0), .bus_rsp1(bus_rsp1),
        .snoop0(snoop0), .snoop1(snoop1),
        .snoop_rsp0(snoop_rsp0), .snoop_rsp1(snoop_rsp1),
        .memory_req(memory_req), .memory_rdata(memory_rdata),
        .memory_busy(memory_busy)
    );

endmodule

// File: cache_stress_assertions.sv
module cache_stress_assertions (
    input logic                      CLK,
    input logic                      reset,
    input cache_geom_pkg::mem_req_t  memory_req,
    input logic                      cache0_flush_done,
    input logic                      cache1_flush_done,
    input cache_geom_pkg::proc_rsp_t cache0_rsp,
    input cache_geom_pkg::proc_rsp_t cache1_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    mem_exclusive: assert property (@(posedge CLK) !(memory_req.ren && memory_req.wen))
        else begin
            failures++;
            $error("Memory read and write requested in the same cycle");
        end

    // Registered pulse, so it is checked one cycle after reset is seen
    flush_quiet_in_reset: assert property (@(posedge CLK)
        reset |=> !cache0_flush_done && !cache1_flush_done)
        else begin
            failures++;
            $error("flush_done high while reset was asserted");
        end

    idle_after_reset: assert property (@(posedge CLK)
        $fell(reset) |-> !cache0_rsp.busy && !cache1_rsp.busy)
        else begin
            failures++;
            $error("Processor busy high right after reset");
        end

endmodule

bind cache_stress_wrapper cache_stress_assertions checks (
    .CLK(CLK),
    .reset(reset),
    .memory_req(memory_req),
    .cache0_flush_done(cache0_flush_done),
    .cache1_flush_done(cache1_flush_done),
    .cache0_rsp(cache0_rsp),
    .cache1_rsp(cache1_rsp)
);

// File: cache_stress_tb.sv
module cache_stress_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_wait = 400;

    logic                      CLK = 1'b0;
    logic                      reset;
    logic                      cache0_flush, cache1_flush;
    logic                      cache0_flush_done, cache1_flush_done;
    cache_geom_pkg::proc_req_t cache0_req, cache1_req;
    cache_geom_pkg::proc_rsp_t cache0_rsp, cache1_rsp;
    cache_geom_pkg::mem_req_t  memory_req;
    cache_geom_pkg::word_t     memory_rdata = '0;
    logic                      memory_busy = 1'b0;
    coherence_pkg::coh_stats_t cache0_stats, cache1_stats;

    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    int          wait_cnt = 0;
    int          seed = 97;
    int          value_errors = 0;
    int          other_errors = 0;
    int          latency;

    cache_stress_wrapper UUT (.*);

    always #10 CLK = ~CLK;

    ////////////////////////////////////////////////////////////
    // Main memory model with random back-pressure
    ////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        if (reset) begin
            wait_cnt = 0;
        end else if (memory_req.ren || memory_req.wen) begin
            if (wait_cnt == 0) begin
                if (memory_req.wen)
                    mem[memory_req.addr[9:2]] = memory_req.wdata;
                // Stall length for the next word, 0 to 2 cycles
                wait_cnt = {$random(seed)} % 3;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
        #2;
        memory_busy  = wait_cnt != 0;
        memory_rdata = mem[memory_req.addr[9:2]];
    end

    function automatic logic [31:0] fill_word(input int i);
        return {8'hC0, i[7:0], ~i[7:0], i[7:0] ^ 8'h5A};
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp) else begin
            value_errors++;
            $display("FAILED t=%0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // One processor access, held until busy drops; reads are checked against ref_mem
    task automatic do_access(input int port, input logic wr, input logic [31:0] address,
                             input logic [31:0] wdata);
        cache_geom_pkg::proc_req_t req;
        cache_geom_pkg::proc_rsp_t rsp;
        logic                      finished;
        logic [31:0]               rdata;
        req = '{addr: address, wdata: wdata, ren: !wr, wen: wr};
        if (port == 0)
            cache0_req = req;
        else
            cache1_req = req;
        finished = 1'b0;
        rdata    = '0;
        latency  = 0;
        while (!finished && latency < max_wait) begin
            @(negedge CLK);
            rsp = port == 0 ? cache0_rsp : cache1_rsp;
            if (!rsp.busy) begin
                finished = 1'b1;
                rdata    = rsp.rdata;
            end
            @(posedge CLK);
            #2;
            if (!finished)
                latency++;
        end
        if (port == 0)
            cache0_req = '0;
        else
            cache1_req = '0;
        assert (finished) else begin
            other_errors++;
            $display("Access by cache%0d to address %h did not finish in time", port, address);
        end
        if (finished && wr)
            ref_mem[address[9:2]] = wdata;
        else if (finished)
            compare_word($sformatf("cache%0d_rsp.rdata at %h", port, address), rdata,
                         ref_mem[address[9:2]]);
    endtask

    task automatic flush_cache(input int port);
        int   cycles;
        logic seen;
        if (port == 0)
            cache0_flush = 1'b1;
        else
            cache1_flush = 1'b1;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < max_wait) begin
            @(negedge CLK);
            seen = port == 0 ? cache0_flush_done : cache1_flush_done;
            @(posedge CLK);
            #2;
            cycles++;
        end
        if (port == 0)
            cache0_flush = 1'b0;
        else
            cache1_flush = 1'b0;
        assert (seen) else begin
            other_errors++;
            $display("Flush of cache%0d never signalled flush_done", port);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic write_then_read;
        logic [31:0] e_before;
        e_before = cache0_stats.to_e_transitions;
        do_access(0, 1'b0, 32'h10, '0);
        compare_word("cache0_stats.to_e_transitions", cache0_stats.to_e_transitions,
                     e_before + 1);
        do_access(0, 1'b1, 32'h24, 32'hDEAD_0001);
        do_access(0, 1'b0, 32'h24, '0);
    endtask

    task automatic shared_read;
        logic [31:0] sb0, sb1, ts0, ts1;
        sb0 = cache0_stats.shared_blocks;
        sb1 = cache1_stats.shared_blocks;
        ts0 = cache0_stats.to_s_transitions;
        ts1 = cache1_stats.to_s_transitions;
        do_access(0, 1'b0, 32'h44, '0);
        do_access(1, 1'b0, 32'h44, '0);
        compare_word("cache0_stats.shared_blocks", cache0_stats.shared_blocks, sb0 + 1);
        compare_word("cache1_stats.shared_blocks", cache1_stats.shared_blocks, sb1 + 1);
        compare_word("cache0_stats.to_s_transitions", cache0_stats.to_s_transitions, ts0 + 1);
        compare_word("cache1_stats.to_s_transitions", cache1_stats.to_s_transitions, ts1 + 1);
    endtask

    task automatic write_invalidates;
        logic [31:0] inv_before;
        inv_before = cache0_stats.invalidated_blocks;
        do_access(1, 1'b1, 32'h40, 32'hBEEF_0002);
        compare_word("cache0_stats.invalidated_blocks", cache0_stats.invalidated_blocks,
                     inv_before + 1);
        // Cache 1 holds the block dirty, so this read forces its writeback
        do_access(0, 1'b0, 32'h40, '0);
        compare_word("memory word 040", mem[8'h10], 32'hBEEF_0002);
    endtask

    task automatic flush_writeback;
        logic [31:0] addrs [4];
        addrs = '{32'h80, 32'h88, 32'h94, 32'h9C};
        foreach (addrs[i])
            do_access(0, 1'b1, addrs[i], 32'hF1F0_0000 + i);
        flush_cache(0);
        flush_cache(1);
        foreach (addrs[i])
            compare_word($sformatf("memory word %h", addrs[i]), mem[addrs[i][9:2]],
                         ref_mem[addrs[i][9:2]]);
        foreach (addrs[i]) begin
            do_access(0, 1'b0, addrs[i], '0);
            assert (latency > 0) else begin
                other_errors++;
                $display("Read of %h after the flush hit in cache0", addrs[i]);
            end
        end
    endtask

    task automatic random_stress;
        int          port;
        int          blk;
        int          word;
        logic        wr;
        logic [31:0] address;
        for (int n = 0; n < 200; n++) begin
            blk     = {$random(seed)} % 8;
            word    = {$random(seed)} % 2;
            port    = {$random(seed)} % 2;
            wr      = ({$random(seed)} % 2) != 0;
            // Four sets, two tags each, so victims get evicted
            address = 32'h200 + blk % 4 * 8 + blk / 4 * 128 + word * 4;
            do_access(port, wr, address, {$random(seed)});
        end
    endtask

    initial begin
        reset        = 1'b1;
        cache0_flush = 1'b0;
        cache1_flush = 1'b0;
        cache0_req   = '0;
        cache1_req   = '0;
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)]     = fill_word(i);
            ref_mem[8'(i)] = fill_word(i);
        end
        repeat (16) @(posedge CLK);
        #2;
        reset = 1'b0;
        @(posedge CLK);
        #2;
        write_then_read();
        shared_read();
        write_invalidates();
        flush_writeback();
        random_stress();
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, UUT.checks.failures);
        if (value_errors + other_errors + UUT.checks.failures == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: flist.f
cache_geom_pkg.sv
coherence_pkg.sv
l1_cache.sv
bus_ctrl.sv
cache_stress_wrapper.sv
cache_stress_assertions.sv
cache_stress_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module cache_stress_tb -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+100 | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
